// File: logic/ft_alu_pkg.sv
`default_nettype none

package ft_alu_pkg;

	////////////////////////////////////////////////////////////
	// replica and voter geometry
	////////////////////////////////////////////////////////////

	// four identical ALUs, three of them feed the voters
	localparam int NUM_REPLICAS = 4;
	localparam int NUM_SLOTS    = 3;
	// replica 3 is the standby that any voter slot can fall back to
	localparam int SPARE_IDX    = 3;

	// operand width of the integer datapath
	localparam int DATA_W = 32;

	typedef logic [DATA_W-1:0] data_t;

	////////////////////////////////////////////////////////////
	// operations and transfer records
	////////////////////////////////////////////////////////////

	// integer subset of the core ALU, compares last
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		AND  = 4'd2,
		OR   = 4'd3,
		XOR  = 4'd4,
		SLL  = 4'd5,
		SRL  = 4'd6,
		SRA  = 4'd7,
		SLT  = 4'd8,
		SLTU = 4'd9,
		EQ   = 4'd10,
		NE   = 4'd11
	} alu_op_e;

	// request into one replica, 68 bits
	typedef struct packed {
		alu_op_e op;
		data_t   operand_a;
		data_t   operand_b;
	} alu_req_t;

	// response out of one replica, 34 bits
	typedef struct packed {
		data_t result;
		logic  cmp;
		logic  valid;
	} alu_rsp_t;

	// per-replica error counter, wide enough for a large threshold
	localparam int ERR_CNT_W = 9;

	typedef logic [ERR_CNT_W-1:0] err_cnt_t;

endpackage : ft_alu_pkg

`default_nettype wire

// File: logic/alu_replica.sv
`timescale 1ns/10ps
`default_nettype none

module alu_replica import ft_alu_pkg::*; (
	input  wire      clk,
	input  wire      rst_n_i,
	input  alu_req_t req_i,
	input  wire      enable_i,
	input  wire      clock_en_i,
	output alu_rsp_t rsp_o
);

	// captured request and its strobe
	alu_req_t req_q;
	logic     valid_q;

	// compute path
	data_t    res;
	logic     cmp_bit;
	logic     is_cmp;
	logic [4:0] shamt;

	////////////////////////////////////////////////////////////
	// operand register
	////////////////////////////////////////////////////////////

	// clock_en_i low freezes the whole stage, so a standby replica holds still
	// enable_i only decides whether a new request lands
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
			req_q   <= '0;
		end else if (clock_en_i) begin
			valid_q <= enable_i;
			if (enable_i) begin
				req_q <= req_i;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// single cycle compute
	////////////////////////////////////////////////////////////

	always_comb begin
		// only the low five bits shift, as in RV32
		shamt   = req_q.operand_b[4:0];
		res     = '0;
		cmp_bit = 1'b0;
		is_cmp  = 1'b0;
		case (req_q.op)
			ADD:  res = req_q.operand_a + req_q.operand_b;
			SUB:  res = req_q.operand_a - req_q.operand_b;
			AND:  res = req_q.operand_a & req_q.operand_b;
			OR:   res = req_q.operand_a | req_q.operand_b;
			XOR:  res = req_q.operand_a ^ req_q.operand_b;
			SLL:  res = req_q.operand_a << shamt;
			SRL:  res = req_q.operand_a >> shamt;
			SRA:  res = $unsigned($signed(req_q.operand_a) >>> shamt);
			SLT: begin
				is_cmp  = 1'b1;
				cmp_bit = $signed(req_q.operand_a) < $signed(req_q.operand_b);
			end
			SLTU: begin
				is_cmp  = 1'b1;
				cmp_bit = req_q.operand_a < req_q.operand_b;
			end
			EQ: begin
				is_cmp  = 1'b1;
				cmp_bit = req_q.operand_a == req_q.operand_b;
			end
			NE: begin
				is_cmp  = 1'b1;
				cmp_bit = req_q.operand_a != req_q.operand_b;
			end
			default: res = '0;
		endcase
		// compares return the flag zero extended
		if (is_cmp) begin
			res = {{(DATA_W-1){1'b0}}, cmp_bit};
		end
	end

	// cmp stays 0 for non-compare ops
	assign rsp_o.result = res;
	assign rsp_o.cmp    = cmp_bit;
	assign rsp_o.valid  = valid_q;

endmodule : alu_replica

`default_nettype wire

// File: logic/replica_select.sv
`timescale 1ns/10ps
`default_nettype none

module replica_select import ft_alu_pkg::*; (
	input  wire  [NUM_SLOTS-1:0]                sel_mux_i,
	input  alu_rsp_t [NUM_REPLICAS-1:0]         rsp_i,
	output alu_rsp_t [NUM_SLOTS-1:0]            slot_rsp_o,
	input  wire  [NUM_SLOTS-1:0]                slot_mismatch_i,
	output logic [NUM_REPLICAS-1:0]             replica_err_o
);

	// index of the replica that drives each voter slot
	logic [1:0] slot_src [NUM_SLOTS];

	////////////////////////////////////////////////////////////
	// slot source decode
	////////////////////////////////////////////////////////////

	// slot k owns replica k, else borrows the spare
	always_comb begin
		for (int k = 0; k < NUM_SLOTS; k++) begin
			if (sel_mux_i[k]) begin
				slot_src[k] = 2'(k);
			end else begin
				slot_src[k] = 2'(SPARE_IDX);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// muxes toward the voters
	////////////////////////////////////////////////////////////

	// result, cmp and valid move together as one record
	always_comb begin
		for (int k = 0; k < NUM_SLOTS; k++) begin
			slot_rsp_o[k] = rsp_i[slot_src[k]];
		end
	end

	////////////////////////////////////////////////////////////
	// error attribution
	////////////////////////////////////////////////////////////

	// fold slot mismatches back onto the replica that fed them
	// the spare can sit behind several slots, so its flag ORs them all
	// a replica that feeds no slot never sees an error here
	always_comb begin
		replica_err_o = '0;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			replica_err_o[slot_src[k]] = replica_err_o[slot_src[k]] | slot_mismatch_i[k];
		end
	end

endmodule : replica_select

`default_nettype wire

// File: logic/tmr_voter.sv
`timescale 1ns/10ps
`default_nettype none

module tmr_voter #(
	parameter int WIDTH = 32
) (
	input  wire  [2:0][WIDTH-1:0] in_i,
	output logic [WIDTH-1:0]      voted_o,
	output logic [2:0]            mismatch_o,
	output logic                  corrected_o,
	output logic                  uncorrectable_o
);

	// number of voter inputs, fixed for a triple
	localparam int N_IN = 3;

	// how many slots disagree with the vote
	logic [1:0] num_mismatch;

	////////////////////////////////////////////////////////////
	// bitwise majority
	////////////////////////////////////////////////////////////

	// each bit takes the value that at least two inputs agree on
	assign voted_o = (in_i[0] & in_i[1])
	               | (in_i[0] & in_i[2])
	               | (in_i[1] & in_i[2]);

	////////////////////////////////////////////////////////////
	// per slot mismatch
	////////////////////////////////////////////////////////////

	// any differing bit marks the whole slot
	// per bit at most one slot loses, but different bits can blame different slots
	always_comb begin
		for (int k = 0; k < N_IN; k++) begin
			mismatch_o[k] = |(in_i[k] ^ voted_o);
		end
	end

	// population count over the three flags
	always_comb begin
		num_mismatch = '0;
		for (int k = 0; k < N_IN; k++) begin
			num_mismatch = num_mismatch + {1'b0, mismatch_o[k]};
		end
	end

	////////////////////////////////////////////////////////////
	// classification
	////////////////////////////////////////////////////////////

	// one bad slot is masked by the other two
	assign corrected_o = (num_mismatch == 2'd1);

	// two or more bad slots, the vote itself is suspect
	assign uncorrectable_o = (num_mismatch >= 2'd2);

endmodule : tmr_voter

`default_nettype wire

// File: logic/fault_counter.sv
`timescale 1ns/10ps
`default_nettype none

module fault_counter import ft_alu_pkg::*; #(
	parameter int FAULT_THRESHOLD = 16
) (
	input  wire                              clk,
	input  wire                              rst_n_i,
	input  wire                              count_en_i,
	input  wire  [NUM_REPLICAS-1:0]          replica_err_i,
	output err_cnt_t [NUM_REPLICAS-1:0]      err_count_o,
	output logic [NUM_REPLICAS-1:0]          permanent_faulty_o,
	output logic [NUM_REPLICAS-1:0]          perf_fault_pulse_o
);

	// threshold in counter width, saturation point is all ones
	localparam err_cnt_t THRESH  = err_cnt_t'(FAULT_THRESHOLD);
	localparam err_cnt_t CNT_MAX = '1;

	err_cnt_t [NUM_REPLICAS-1:0] cnt_q;
	err_cnt_t [NUM_REPLICAS-1:0] cnt_d;
	logic     [NUM_REPLICAS-1:0] inc;
	logic     [NUM_REPLICAS-1:0] hit;
	logic     [NUM_REPLICAS-1:0] faulty_q;
	logic     [NUM_REPLICAS-1:0] pulse_q;

	////////////////////////////////////////////////////////////
	// next count
	////////////////////////////////////////////////////////////

	// only voted valid operations are counted
	always_comb begin
		for (int r = 0; r < NUM_REPLICAS; r++) begin
			inc[r]   = count_en_i && replica_err_i[r] && (cnt_q[r] != CNT_MAX);
			cnt_d[r] = inc[r] ? cnt_q[r] + err_cnt_t'(1) : cnt_q[r];
			// counter is monotonic, so this fires once per replica
			hit[r]   = inc[r] && (cnt_d[r] == THRESH);
		end
	end

	////////////////////////////////////////////////////////////
	// state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt_q    <= '0;
			faulty_q <= '0;
			pulse_q  <= '0;
		end else begin
			cnt_q    <= cnt_d;
			// sticky until reset
			faulty_q <= faulty_q | hit;
			// one cycle strobe for the perf counter
			pulse_q  <= hit;
		end
	end

	assign err_count_o        = cnt_q;
	assign permanent_faulty_o = faulty_q;
	assign perf_fault_pulse_o = pulse_q;

endmodule : fault_counter

`default_nettype wire

// File: logic/ft_alu_top.sv
`timescale 1ns/10ps
`default_nettype none

module ft_alu_top import ft_alu_pkg::*; #(
	parameter int FAULT_THRESHOLD = 16
) (
	input  wire                              clk,
	input  wire                              rst_n_i,
	input  alu_req_t [NUM_REPLICAS-1:0]      req_i,
	input  wire  [NUM_REPLICAS-1:0]          enable_i,
	input  wire  [NUM_REPLICAS-1:0]          clock_en_i,
	input  wire  [NUM_SLOTS-1:0]             sel_mux_i,
	output data_t                            result_o,
	output logic                             comparison_result_o,
	output logic                             valid_o,
	output logic                             err_corrected_o,
	output logic                             err_detected_o,
	output err_cnt_t [NUM_REPLICAS-1:0]      err_count_o,
	output logic [NUM_REPLICAS-1:0]          permanent_faulty_o,
	output logic [NUM_REPLICAS-1:0]          perf_fault_pulse_o
);

	// replica outputs and what the muxes hand to the voters
	alu_rsp_t [NUM_REPLICAS-1:0]            rsp;
	alu_rsp_t [NUM_SLOTS-1:0]               slot_rsp;

	// voter inputs split by field
	logic [NUM_SLOTS-1:0][DATA_W-1:0]       slot_result;
	logic [NUM_SLOTS-1:0][0:0]              slot_cmp;
	logic [NUM_SLOTS-1:0][0:0]              slot_valid;

	// per voter status
	logic [NUM_SLOTS-1:0]                   mm_result;
	logic [NUM_SLOTS-1:0]                   mm_cmp;
	logic [NUM_SLOTS-1:0]                   mm_valid;
	logic [NUM_SLOTS-1:0]                   slot_mismatch;
	logic                                   corr_result;
	logic                                   corr_cmp;
	logic                                   corr_valid;
	logic                                   unc_result;
	logic                                   unc_cmp;
	logic                                   unc_valid;
	logic [NUM_REPLICAS-1:0]                replica_err;

	////////////////////////////////////////////////////////////
	// replicas
	////////////////////////////////////////////////////////////

	for (genvar r = 0; r < NUM_REPLICAS; r++) begin : g_replica
		alu_replica alu_replica_i (
			.clk        ( clk           ),
			.rst_n_i    ( rst_n_i       ),
			.req_i      ( req_i[r]      ),
			.enable_i   ( enable_i[r]   ),
			.clock_en_i ( clock_en_i[r] ),
			.rsp_o      ( rsp[r]        )
		);
	end

	replica_select replica_select_i (
		.sel_mux_i       ( sel_mux_i     ),
		.rsp_i           ( rsp           ),
		.slot_rsp_o      ( slot_rsp      ),
		.slot_mismatch_i ( slot_mismatch ),
		.replica_err_o   ( replica_err   )
	);

	// unpack the slot records for the three voters
	always_comb begin
		for (int k = 0; k < NUM_SLOTS; k++) begin
			slot_result[k] = slot_rsp[k].result;
			slot_cmp[k]    = slot_rsp[k].cmp;
			slot_valid[k]  = slot_rsp[k].valid;
		end
	end

	////////////////////////////////////////////////////////////
	// voters
	////////////////////////////////////////////////////////////

	tmr_voter #(.WIDTH(DATA_W)) voter_result_i (
		.in_i            ( slot_result ),
		.voted_o         ( result_o    ),
		.mismatch_o      ( mm_result   ),
		.corrected_o     ( corr_result ),
		.uncorrectable_o ( unc_result  )
	);

	tmr_voter #(.WIDTH(1)) voter_cmp_i (
		.in_i            ( slot_cmp            ),
		.voted_o         ( comparison_result_o ),
		.mismatch_o      ( mm_cmp              ),
		.corrected_o     ( corr_cmp            ),
		.uncorrectable_o ( unc_cmp             )
	);

	tmr_voter #(.WIDTH(1)) voter_valid_i (
		.in_i            ( slot_valid ),
		.voted_o         ( valid_o    ),
		.mismatch_o      ( mm_valid   ),
		.corrected_o     ( corr_valid ),
		.uncorrectable_o ( unc_valid  )
	);

	// a slot is bad if any of its three fields lost the vote
	assign slot_mismatch   = mm_result | mm_cmp | mm_valid;
	assign err_corrected_o = corr_result | corr_cmp | corr_valid;
	assign err_detected_o  = unc_result | unc_cmp | unc_valid;

	////////////////////////////////////////////////////////////
	// fault bookkeeping
	////////////////////////////////////////////////////////////

	fault_counter #(.FAULT_THRESHOLD(FAULT_THRESHOLD)) fault_counter_i (
		.clk                ( clk                ),
		.rst_n_i            ( rst_n_i            ),
		.count_en_i         ( valid_o            ),
		.replica_err_i      ( replica_err        ),
		.err_count_o        ( err_count_o        ),
		.permanent_faulty_o ( permanent_faulty_o ),
		.perf_fault_pulse_o ( perf_fault_pulse_o )
	);

endmodule : ft_alu_top

`default_nettype wire

// File: dv/ft_alu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ft_alu_tb import ft_alu_pkg::*; ();

	localparam int FAULT_THRESHOLD = 4;
	localparam int CLK_PERIOD      = 100;
	localparam int RESET_CYCLES    = 5;
	localparam int FLUSH_CYCLES    = 2;

	// requests per phase
	localparam int N_CLEAN   = 40;
	localparam int N_SINGLE  = 20;
	localparam int N_DOUBLE  = 20;
	localparam int N_FAULTY  = 4;
	localparam int N_AFTER   = 4;
	localparam int N_STANDBY = 20;
	localparam int N_HOLD    = 1;
	localparam int N_SPARE   = 20;
	localparam int N_PHASES  = 6;

	// every phase starts with a reset and ends with idle cycles
	localparam int TOTAL_CYCLES = N_PHASES * (RESET_CYCLES + FLUSH_CYCLES)
	                            + N_CLEAN + N_SINGLE + N_DOUBLE + N_FAULTY + N_AFTER
	                            + N_STANDBY + N_HOLD + N_SPARE;

	logic                            clk = 1'b0;
	logic                            rst_n_i;
	alu_req_t [NUM_REPLICAS-1:0]     req_i;
	logic [NUM_REPLICAS-1:0]         enable_i;
	logic [NUM_REPLICAS-1:0]         clock_en_i;
	logic [NUM_SLOTS-1:0]            sel_mux_i;
	data_t                           result_o;
	logic                            comparison_result_o;
	logic                            valid_o;
	logic                            err_corrected_o;
	logic                            err_detected_o;
	err_cnt_t [NUM_REPLICAS-1:0]     err_count_o;
	logic [NUM_REPLICAS-1:0]         permanent_faulty_o;
	logic [NUM_REPLICAS-1:0]         perf_fault_pulse_o;

	integer seed = 32'h44ab;

	// model copy of each replica's captured request and strobe
	alu_req_t [NUM_REPLICAS-1:0]     shadow_req;
	logic [NUM_REPLICAS-1:0]         shadow_val;

	// expected DUT outputs that only change on the falling edge
	data_t                           exp_result;
	logic                            exp_cmp;
	logic                            exp_valid;
	logic                            exp_corr;
	logic                            exp_det;
	logic [NUM_REPLICAS-1:0]         exp_rep_err;
	err_cnt_t [NUM_REPLICAS-1:0]     exp_cnt;
	logic [NUM_REPLICAS-1:0]         exp_faulty;
	logic [NUM_REPLICAS-1:0]         exp_pulse;

	// high cycles of replica 2's threshold pulse
	int                              pulse_seen;

	ft_alu_top #(.FAULT_THRESHOLD(FAULT_THRESHOLD)) ft_alu_top_i (
		.clk                 ( clk                 ),
		.rst_n_i             ( rst_n_i             ),
		.req_i               ( req_i               ),
		.enable_i            ( enable_i            ),
		.clock_en_i          ( clock_en_i          ),
		.sel_mux_i           ( sel_mux_i           ),
		.result_o            ( result_o            ),
		.comparison_result_o ( comparison_result_o ),
		.valid_o             ( valid_o             ),
		.err_corrected_o     ( err_corrected_o     ),
		.err_detected_o      ( err_detected_o      ),
		.err_count_o         ( err_count_o         ),
		.permanent_faulty_o  ( permanent_faulty_o  ),
		.perf_fault_pulse_o  ( perf_fault_pulse_o  )
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	always @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pulse_seen <= 0;
		end else if (perf_fault_pulse_o[2]) begin
			pulse_seen <= pulse_seen + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	task automatic fail_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		$display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, want);
		$display("Simulation finished: FAIL");
		$fatal(1, "output does not match the reference model");
	endtask

	// integer ALU whose shift amount is the low five bits of b
	function automatic void alu_ref(input alu_req_t q, output data_t res, output logic cmp);
		logic [4:0] sh;
		sh  = q.operand_b[4:0];
		res = '0;
		cmp = 1'b0;
		case (q.op)
			ADD:     res = q.operand_a + q.operand_b;
			SUB:     res = q.operand_a - q.operand_b;
			AND:     res = q.operand_a & q.operand_b;
			OR:      res = q.operand_a | q.operand_b;
			XOR:     res = q.operand_a ^ q.operand_b;
			SLL:     res = q.operand_a << sh;
			SRL:     res = q.operand_a >> sh;
			SRA:     res = data_t'($signed(q.operand_a) >>> sh);
			SLT:     cmp = $signed(q.operand_a) < $signed(q.operand_b);
			SLTU:    cmp = q.operand_a < q.operand_b;
			EQ:      cmp = (q.operand_a == q.operand_b);
			NE:      cmp = (q.operand_a != q.operand_b);
			default: res = '0;
		endcase
		// compares put the flag into bit 0 of the result
		if (q.op inside {SLT, SLTU, EQ, NE}) begin
			res = data_t'(cmp);
		end
	endfunction

	// per bit majority by counting ones
	// each slot mismatches if it differs from the vote
	function automatic void vote3(input data_t a, input data_t b, input data_t c,
		output data_t v, output logic [2:0] mm);
		for (int i = 0; i < DATA_W; i++) begin
			v[i] = (int'(a[i]) + int'(b[i]) + int'(c[i])) >= 2;
		end
		mm[0] = (a != v);
		mm[1] = (b != v);
		mm[2] = (c != v);
	endfunction

	// what the outputs show until the next rising edge
	function automatic void compute_expected();
		data_t      rep_res [NUM_REPLICAS];
		logic       rep_cmp [NUM_REPLICAS];
		logic [1:0] src [NUM_SLOTS];
		data_t      v;
		logic [2:0] mm_res;
		logic [2:0] mm_cmp;
		logic [2:0] mm_val;
		logic [2:0] slot_bad;
		for (int r = 0; r < NUM_REPLICAS; r++) begin
			alu_ref(shadow_req[r], rep_res[r], rep_cmp[r]);
		end
		// slot k falls back to the spare when its select is low
		for (int k = 0; k < NUM_SLOTS; k++) begin
			src[k] = sel_mux_i[k] ? 2'(k) : 2'(SPARE_IDX);
		end
		vote3(rep_res[src[0]], rep_res[src[1]], rep_res[src[2]], exp_result, mm_res);
		vote3(data_t'(rep_cmp[src[0]]), data_t'(rep_cmp[src[1]]), data_t'(rep_cmp[src[2]]),
			v, mm_cmp);
		exp_cmp = v[0];
		vote3(data_t'(shadow_val[src[0]]), data_t'(shadow_val[src[1]]),
			data_t'(shadow_val[src[2]]), v, mm_val);
		exp_valid = v[0];
		exp_corr  = ($countones(mm_res) == 1) || ($countones(mm_cmp) == 1)
		          || ($countones(mm_val) == 1);
		exp_det   = ($countones(mm_res) >= 2) || ($countones(mm_cmp) >= 2)
		          || ($countones(mm_val) >= 2);
		// blame goes to whichever replica sat behind the bad slot
		slot_bad    = mm_res | mm_cmp | mm_val;
		exp_rep_err = '0;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			exp_rep_err[src[k]] = exp_rep_err[src[k]] | slot_bad[k];
		end
	endfunction

	// effect of the rising edge that just passed
	function automatic void advance_model();
		err_cnt_t nxt;
		for (int r = 0; r < NUM_REPLICAS; r++) begin
			exp_pulse[r] = 1'b0;
			if (exp_valid && exp_rep_err[r] && exp_cnt[r] != '1) begin
				nxt        = exp_cnt[r] + err_cnt_t'(1);
				exp_cnt[r] = nxt;
				if (nxt == err_cnt_t'(FAULT_THRESHOLD)) begin
					exp_faulty[r] = 1'b1;
					exp_pulse[r]  = 1'b1;
				end
			end
			// gated capture so a standby replica keeps everything
			if (clock_en_i[r]) begin
				shadow_val[r] = enable_i[r];
				if (enable_i[r]) begin
					shadow_req[r] = req_i[r];
				end
			end
		end
	endfunction

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic alu_req_t random_req();
		alu_req_t q;
		q.op        = alu_op_e'(4'($unsigned($random(seed)) % 12));
		q.operand_a = data_t'($random(seed));
		q.operand_b = data_t'($random(seed));
		// equal operands now and then so EQ and NE see both outcomes
		if (($random(seed) & 3) == 0) begin
			q.operand_b = q.operand_a;
		end
		return q;
	endfunction

	function automatic alu_req_t flip_operand(input alu_req_t q, input data_t mask);
		alu_req_t f;
		f           = q;
		f.operand_a = q.operand_a ^ mask;
		return f;
	endfunction

	task automatic drive(input alu_req_t [NUM_REPLICAS-1:0] reqs,
		input logic [NUM_REPLICAS-1:0] en, input logic [NUM_REPLICAS-1:0] ce,
		input logic [NUM_SLOTS-1:0] sel);
		@(negedge clk);
		advance_model();
		req_i      = reqs;
		enable_i   = en;
		clock_en_i = ce;
		sel_mux_i  = sel;
		compute_expected();
	endtask

	// idle cycles so the last request reaches the checks
	task automatic flush();
		repeat (FLUSH_CYCLES) begin
			drive(req_i, '0, clock_en_i, sel_mux_i);
		end
	endtask

	task automatic apply_reset();
		rst_n_i    = 1'b0;
		req_i      = '0;
		enable_i   = '0;
		clock_en_i = '1;
		sel_mux_i  = '1;
		shadow_req = '0;
		shadow_val = '0;
		exp_cnt    = '0;
		exp_faulty = '0;
		exp_pulse  = '0;
		compute_expected();
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n_i = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// checks on the rising edge
	////////////////////////////////////////////////////////////

	result_check: assert property (@(posedge clk) disable iff (!rst_n_i)
		!exp_valid || (result_o == exp_result))
		else fail_value("result_o", 64'($sampled(result_o)), 64'($sampled(exp_result)));
	cmp_check: assert property (@(posedge clk) disable iff (!rst_n_i)
		!exp_valid || (comparison_result_o == exp_cmp))
		else fail_value("comparison_result_o", 64'($sampled(comparison_result_o)),
			64'($sampled(exp_cmp)));
	valid_check: assert property (@(posedge clk) disable iff (!rst_n_i) valid_o == exp_valid)
		else fail_value("valid_o", 64'($sampled(valid_o)), 64'($sampled(exp_valid)));
	corr_check: assert property (@(posedge clk) disable iff (!rst_n_i)
		err_corrected_o == exp_corr)
		else fail_value("err_corrected_o", 64'($sampled(err_corrected_o)),
			64'($sampled(exp_corr)));
	det_check: assert property (@(posedge clk) disable iff (!rst_n_i)
		err_detected_o == exp_det)
		else fail_value("err_detected_o", 64'($sampled(err_detected_o)),
			64'($sampled(exp_det)));
	count_check: assert property (@(posedge clk) disable iff (!rst_n_i) err_count_o == exp_cnt)
		else fail_value("err_count_o", 64'($sampled(err_count_o)), 64'($sampled(exp_cnt)));
	faulty_check: assert property (@(posedge clk) disable iff (!rst_n_i)
		permanent_faulty_o == exp_faulty)
		else fail_value("permanent_faulty_o", 64'($sampled(permanent_faulty_o)),
			64'($sampled(exp_faulty)));
	pulse_check: assert property (@(posedge clk) disable iff (!rst_n_i)
		perf_fault_pulse_o == exp_pulse)
		else fail_value("perf_fault_pulse_o", 64'($sampled(perf_fault_pulse_o)),
			64'($sampled(exp_pulse)));

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		alu_req_t                    base;
		alu_req_t [NUM_REPLICAS-1:0] reqs;
		logic                        en_bit;
		data_t                       flip_a;
		data_t                       flip_b;
		// clean traffic with about one request in four left idle
		apply_reset();
		for (int i = 0; i < N_CLEAN; i++) begin
			base   = random_req();
			en_bit = ($random(seed) & 3) != 0;
			reqs   = {NUM_REPLICAS{base}};
			drive(reqs, {NUM_REPLICAS{en_bit}}, '1, '1);
		end
		flush();
		// replica 0 alone disagrees
		apply_reset();
		for (int i = 0; i < N_SINGLE; i++) begin
			base    = random_req();
			flip_a  = data_t'($random(seed)) | 32'h1;
			reqs    = {NUM_REPLICAS{base}};
			reqs[0] = flip_operand(base, flip_a);
			drive(reqs, '1, '1, '1);
		end
		flush();
		// replicas 0 and 1 disagree in different bits
		apply_reset();
		for (int i = 0; i < N_DOUBLE; i++) begin
			base    = random_req();
			flip_a  = (data_t'($random(seed)) & ~32'h2) | 32'h1;
			flip_b  = (data_t'($random(seed)) & ~32'h1) | 32'h2;
			reqs    = {NUM_REPLICAS{base}};
			reqs[0] = flip_operand(base, flip_a);
			reqs[1] = flip_operand(base, flip_b);
			drive(reqs, '1, '1, '1);
		end
		flush();
		// replica 2 wrong until it hits the threshold
		// XOR keeps every flipped bit visible in the result
		apply_reset();
		for (int i = 0; i < N_FAULTY + N_AFTER; i++) begin
			base    = random_req();
			base.op = XOR;
			reqs    = {NUM_REPLICAS{base}};
			if (i < N_FAULTY) begin
				reqs[2] = flip_operand(base, data_t'($random(seed)) | 32'h1);
			end
			drive(reqs, '1, '1, '1);
		end
		flush();
		assert (err_count_o[2] == err_cnt_t'(FAULT_THRESHOLD))
			else fail_value("err_count_o[2]", 64'(err_count_o[2]), 64'(FAULT_THRESHOLD));
		assert (permanent_faulty_o[2])
			else fail_value("permanent_faulty_o[2]", 64'(permanent_faulty_o[2]), 64'd1);
		assert (pulse_seen == 1)
			else fail_value("perf_fault_pulse_o[2] high cycles", 64'(pulse_seen), 64'd1);
		// replica 1 parked behind the spare and clock gated
		apply_reset();
		for (int i = 0; i < N_STANDBY; i++) begin
			base    = random_req();
			reqs    = {NUM_REPLICAS{base}};
			reqs[1] = flip_operand(base, data_t'($random(seed)) | 32'h1);
			drive(reqs, '1, 4'b1101, 3'b101);
		end
		// all clocks gated, so the last result stays valid
		repeat (N_HOLD) begin
			drive(reqs, '0, '0, 3'b101);
		end
		flush();
		// the spare is wrong but feeds no slot
		apply_reset();
		for (int i = 0; i < N_SPARE; i++) begin
			base    = random_req();
			reqs    = {NUM_REPLICAS{base}};
			reqs[3] = flip_operand(base, data_t'($random(seed)) | 32'h1);
			drive(reqs, '1, '1, '1);
		end
		flush();
		$display("Simulation finished: PASS");
		$finish;
	end

	initial begin
		#((TOTAL_CYCLES + 50) * CLK_PERIOD);
		$display("timeout: the test sequence did not complete in time");
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule : ft_alu_tb

`default_nettype wire

// File: all.f
logic/ft_alu_pkg.sv
logic/alu_replica.sv
logic/replica_select.sv
logic/tmr_voter.sv
logic/fault_counter.sv
logic/ft_alu_top.sv
dv/ft_alu_tb.sv

// File: Makefile
TOP := ft_alu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
